// File: sim.f
+incdir+src
src/Types.sv
src/CacheWay.sv
src/CacheLookup.sv
src/CacheHitSelect.sv
src/InstL1Cache.sv
src/InstMemSystem.sv
bench/InstMemModel.sv
bench/InstMemSystemTb.sv

// File: Makefile
# Verilator build and run of the instruction memory system testbench

TOP = InstMemSystemTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module InstMemSystem +incdir+src \
		src/Types.sv src/CacheWay.sv src/CacheLookup.sv \
		src/CacheHitSelect.sv src/InstL1Cache.sv src/InstMemSystem.sv

clean:
	rm -rf obj_dir sim.log

// File: bench/InstMemSystemTb.sv
// ------------------------------------------------------------------------
// Testbench of the instruction memory system. Applies a table of core reads
// against a rule-based memory model and checks words, hits and refills.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module InstMemSystemTb
    import Types::*;
();

    localparam int  ResetCycles = 16;
    localparam int  Rows        = 20;
    localparam Inst WordPattern = 32'h5A3C_96E1;          // Same rule as the model
    localparam int  CycleLimit  = Rows * (`RV_ICACHE_LINE_WORDS + 2) * 8 + ResetCycles;

    typedef enum logic [1:0] {CheckData, CheckHit, CheckRefill, CheckIdle} CheckKind;

    typedef struct packed {
        InstAddr  addr;     // Core address
        logic     re;       // Core read
        logic     stall;    // Memory stalls on
        CheckKind kind;     // What the row checks
    } StimRow;

    StimRow  stim [Rows];
    logic    clock;
    logic    rst;
    InstAddr coreAddr;
    logic    coreRe;
    Inst     coreInst;
    logic    coreBusy;
    InstAddr memAddr;
    logic    memRe;
    Inst     memInst;
    logic    memBusy;
    logic    stallEn;
    int      errors;
    int      checks;
    int      cycles;

    InstMemSystem dut0 (
        .i_clock   (clock),
        .i_rst     (rst),
        .i_addr    (coreAddr),
        .i_re      (coreRe),
        .o_inst    (coreInst),
        .o_busy    (coreBusy),
        .o_memAddr (memAddr),
        .o_memRe   (memRe),
        .i_memInst (memInst),
        .i_memBusy (memBusy));

    InstMemModel #(.Pattern(WordPattern), .Seed(47443)) memModel (
        .i_clock   (clock),
        .i_rst     (rst),
        .i_addr    (memAddr),
        .i_re      (memRe),
        .i_stallEn (stallEn),
        .o_inst    (memInst),
        .o_busy    (memBusy));

    always #5 clock = ~clock;   // 10 ns period

    // ---------------------------------------------------------------------
    // Expected values and compare tasks
    // ---------------------------------------------------------------------

    // Word address XOR pattern
    function automatic Inst ruleWord(input InstAddr a);
        return Inst'(a >> 2) ^ WordPattern;
    endfunction

    // Memory address of the given fetch within the request's line
    function automatic InstAddr fetchAddr(input InstAddr a, input int word);
        if (`RV_ICACHE_ON == 0)
            return a;                         // Bypass passes the core address
        return (a & ~InstAddr'(`RV_ICACHE_LINE_WORDS * 4 - 1)) + InstAddr'(word * 4);
    endfunction

    task automatic checkWord(input string name, input Inst got, input Inst exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic matchAddr(input string name, input InstAddr got, input InstAddr exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expectFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Drive one row after the edge, sample at falling edges
    task automatic applyRow(input int r);
        StimRow   row;
        CheckKind kind;
        int       errBefore;
        int       takes;
        logic     firstBusy;
        logic     sawMemRe;
        logic     lastCycle;
        row       = stim[r];
        kind      = row.kind;
        errBefore = errors;
        if (`RV_ICACHE_ON == 0 && kind != CheckIdle)
            kind = CheckData;                 // Bypass never hits
        @(posedge clock);
        #1;
        coreAddr = row.addr;
        coreRe   = row.re;
        stallEn  = row.stall;
        @(negedge clock);
        if (kind == CheckIdle) begin
            repeat (3) begin
                expectFlag("o_busy", coreBusy, 1'b0);
                expectFlag("o_memRe", memRe, 1'b0);
                @(negedge clock);
            end
        end
        else begin
            firstBusy = coreBusy;             // Request cycle
            sawMemRe  = 1'b0;
            takes     = 0;
            lastCycle = 1'b0;
            while (!lastCycle) begin
                if (memRe) begin
                    sawMemRe = 1'b1;
                    matchAddr("o_memAddr", memAddr, fetchAddr(row.addr, takes));
                    if (!memBusy)
                        takes++;              // Word taken at the next edge
                end
                lastCycle = !coreBusy;
                if (!lastCycle)
                    @(negedge clock);
            end
            checkWord("o_inst", coreInst, ruleWord(row.addr));
            if (kind == CheckHit) begin
                expectFlag("o_busy", firstBusy, 1'b0);
                expectFlag("o_memRe", sawMemRe, 1'b0);
            end
            else if (kind == CheckRefill)
                expectFlag("o_memRe", sawMemRe, 1'b1);
        end
        $display("row %0d %s addr %h: %s", r, kind.name(), row.addr,
                 (errors == errBefore) ? "ok" : "error");
    endtask

    // ---------------------------------------------------------------------
    // Watchdog
    // ---------------------------------------------------------------------

    initial begin
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT never ended a request", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ---------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------

    initial begin
        clock    = 1'b0;
        rst      = 1'b1;
        coreAddr = '0;
        coreRe   = 1'b0;
        stallEn  = 1'b0;
        errors   = 0;
        checks   = 0;

        // Set 0 lines at 0x1000, 0x1040, 0x1080 for replacement
        stim[0]  = '{32'h0000_1000, 1'b1, 1'b0, CheckRefill};  // Cold miss
        stim[1]  = '{32'h0000_1000, 1'b1, 1'b0, CheckHit};     // Repeat
        stim[2]  = '{32'h0000_1004, 1'b1, 1'b0, CheckHit};     // Rest of line
        stim[3]  = '{32'h0000_1008, 1'b1, 1'b0, CheckHit};
        stim[4]  = '{32'h0000_100C, 1'b1, 1'b0, CheckHit};
        stim[5]  = '{32'h0000_0000, 1'b0, 1'b0, CheckIdle};
        stim[6]  = '{32'h0000_1040, 1'b1, 1'b0, CheckRefill};  // Way 1
        stim[7]  = '{32'h0000_1080, 1'b1, 1'b0, CheckRefill};  // Evicts 0x1000
        stim[8]  = '{32'h0000_1084, 1'b1, 1'b0, CheckHit};
        stim[9]  = '{32'h0000_1000, 1'b1, 1'b0, CheckRefill};  // Evicted line back
        stim[10] = '{32'h0000_1088, 1'b1, 1'b0, CheckHit};     // Newest still in
        stim[11] = '{32'h0000_2010, 1'b1, 1'b1, CheckRefill};  // Stalls from here
        stim[12] = '{32'h0000_2018, 1'b1, 1'b1, CheckHit};
        stim[13] = '{32'h0000_3020, 1'b1, 1'b1, CheckData};
        stim[14] = '{32'h0000_302C, 1'b1, 1'b1, CheckData};
        stim[15] = '{32'h0000_4430, 1'b1, 1'b1, CheckRefill};
        stim[16] = '{32'h0000_443C, 1'b1, 1'b1, CheckData};
        stim[17] = '{32'h0000_1040, 1'b1, 1'b1, CheckRefill};  // Evicts 0x1080
        stim[18] = '{32'h0000_0000, 1'b0, 1'b1, CheckIdle};
        stim[19] = '{32'h0000_1000, 1'b1, 1'b1, CheckHit};

        repeat (ResetCycles) @(posedge clock);
        #1;
        rst = 1'b0;

        for (int r = 0; r < Rows; r++)
            applyRow(r);

        @(posedge clock);
        #1;
        coreRe = 1'b0;
        $display("rows %0d checks %0d errors %0d", Rows, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: bench/InstMemModel.sv
// ------------------------------------------------------------------------
// Behavioral instruction memory on the global bus. Any address returns its
// word address XOR a fixed pattern; i_stallEn adds random busy cycles.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module InstMemModel
    import Types::*;
#(
    parameter Inst         Pattern = 32'h5A3C_96E1, // Fill pattern
    parameter int unsigned Seed    = 1              // Busy generator seed
)
(
    input  logic    i_clock,    // Clock
    input  logic    i_rst,      // Sync reset, no stalls
    input  InstAddr i_addr,     // Read address
    input  logic    i_re,       // Read request
    input  logic    i_stallEn,  // Random busy on
    output Inst     o_inst,     // Word at i_addr
    output logic    o_busy);    // Back-pressure

    logic stall;                // Stall draw of the current cycle

    // ---------------------------------------------------------------------
    // Data, always valid for the address on the bus
    // ---------------------------------------------------------------------

    // Word address sits in bits above the byte lane
    assign o_inst = {2'b00, i_addr[`RV_ADDR_WIDTH-1:2]} ^ Pattern;

    // Busy only while a read is asked for
    assign o_busy = i_re && stall;

    // ---------------------------------------------------------------------
    // Busy generator
    // ---------------------------------------------------------------------

    // Seeded in the same process that draws, so the sequence is repeatable
    initial begin
        stall = 1'b0;
        void'($urandom(Seed));
        forever begin
            @(posedge i_clock);
            #1;                                 // Same drive point as the core side
            if (i_rst || !i_stallEn)
                stall = 1'b0;
            else
                stall = ($urandom % 32'd3) != 32'd0; // Two cycles in three stalled
        end
    end

    // A stalled take keeps o_inst stable since the
    // requester holds its address until busy drops

endmodule

// File: src/InstMemSystem.sv
// ------------------------------------------------------------------------
// Instruction side of the memory system. Joins the core instruction bus
// to the global instruction bus through the L1 cache or a plain bypass.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module InstMemSystem
    import Types::*;
(
    input  logic    i_clock,    // Clock
    input  logic    i_rst,      // Sync reset
    input  InstAddr i_addr,     // Core address
    input  logic    i_re,       // Core read
    output Inst     o_inst,     // Word to core
    output logic    o_busy,     // Core wait
    output InstAddr o_memAddr,  // Global bus address
    output logic    o_memRe,    // Global bus read
    input  Inst     i_memInst,  // Global bus word
    input  logic    i_memBusy); // Global bus wait

    // ---------------------------------------------------------------------
    // L1 instruction cache or bypass
    // ---------------------------------------------------------------------

    generate
        if (`RV_ICACHE_ON == 1) begin : cacheGen
            InstL1Cache
            instL1Cache (
                .i_clock   (i_clock),
                .i_rst     (i_rst),
                .i_addr    (i_addr),
                .i_re      (i_re),
                .o_inst    (o_inst),
                .o_busy    (o_busy),
                .o_memAddr (o_memAddr),
                .o_memRe   (o_memRe),
                .i_memInst (i_memInst),
                .i_memBusy (i_memBusy));
        end
        else begin : bypassGen
            assign o_memAddr = i_addr;     // Latency is the memory's own
            assign o_memRe   = i_re;
            assign o_inst    = i_memInst;
            assign o_busy    = i_memBusy;
        end
    endgenerate

endmodule

// File: src/InstL1Cache.sv
// ------------------------------------------------------------------------
// L1 instruction cache between the core bus and the global memory bus.
// Hits return in the request cycle; a miss refills the whole line first.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module InstL1Cache
    import Types::*;
(
    input  logic    i_clock,    // Clock
    input  logic    i_rst,      // Sync reset
    input  InstAddr i_addr,     // Core request address
    input  logic    i_re,       // Core read request
    output Inst     o_inst,     // Word to core
    output logic    o_busy,     // Core must wait
    output InstAddr o_memAddr,  // Memory address
    output logic    o_memRe,    // Memory read request
    input  Inst     i_memInst,  // Word from memory
    input  logic    i_memBusy); // Memory not ready

    localparam CacheOffset LastOffset = CacheOffset'(`RV_ICACHE_LINE_WORDS - 1);

    RefillState state;          // Refill controller
    CacheOffset fillOffset;     // Word being fetched

    CacheIndex  index;          // Request fields
    CacheTag    tag;
    CacheOffset offset;
    WayMask     fillWay;        // One-hot victim

    WayMask     wayHits;        // Per-way hit
    Inst [`RV_ICACHE_WAYS-1:0] wayWords;
    logic       hit;            // Merged hit

    logic       wordTake;       // Memory word accepted this cycle
    logic       lineDone;       // Finish strobe

    // ---------------------------------------------------------------------
    // Refill controller
    // ---------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= Idle;
            fillOffset <= '0;
        end
        else begin
            case (state)
                Idle: begin
                    fillOffset <= '0;            // Line fills from word 0
                    if (i_re && !hit)
                        state <= Fill;
                end
                Fill:
                    if (!i_memBusy) begin        // Word taken
                        fillOffset <= fillOffset + CacheOffset'(1);
                        if (fillOffset == LastOffset)
                            state <= Finish;
                    end
                Finish:
                    state <= Idle;               // Next cycle hits
                default:
                    state <= Idle;
            endcase
        end
    end

    assign wordTake = (state == Fill) && !i_memBusy;
    assign lineDone = (state == Finish);

    // Memory side, address held while memory is busy
    assign o_memRe   = (state == Fill);
    assign o_memAddr = {tag, index, fillOffset, 2'b00};

    // Core side
    assign o_busy = i_re && !hit;

    // ---------------------------------------------------------------------
    // Lookup, ways and merge
    // ---------------------------------------------------------------------

    CacheLookup
    cacheLookup (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_addr     (i_addr),
        .i_lineDone (lineDone),
        .o_index    (index),
        .o_tag      (tag),
        .o_offset   (offset),
        .o_fillWay  (fillWay));

    generate
        for (genvar w = 0; w < `RV_ICACHE_WAYS; w++) begin : wayGen
            CacheWay
            cacheWay (
                .i_clock      (i_clock),
                .i_rst        (i_rst),
                .i_index      (index),
                .i_tag        (tag),
                .i_offset     (offset),
                .i_fillEn     (fillWay[w] && wordTake),  // Victim only
                .i_fillOffset (fillOffset),
                .i_fillWord   (i_memInst),
                .i_lineDone   (fillWay[w] && lineDone),
                .o_hit        (wayHits[w]),
                .o_word       (wayWords[w]));
        end
    endgenerate

    CacheHitSelect
    hitSelect (
        .i_hits  (wayHits),
        .i_words (wayWords),
        .o_hit   (hit),
        .o_inst  (o_inst));

endmodule

// File: src/CacheHitSelect.sv
// ------------------------------------------------------------------------
// Output merge of the cache ways. ORs the hit flags and picks the word of
// the hitting way; gives zero when no way hits.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module CacheHitSelect
    import Types::*;
(
    input  WayMask                     i_hits,  // Hit flag per way
    input  Inst [`RV_ICACHE_WAYS-1:0]  i_words, // Read word per way
    output logic                       o_hit,   // Any way hits
    output Inst                        o_inst); // Merged word

    // Any hit at all
    assign o_hit = |i_hits;

    // ---------------------------------------------------------------------
    // AND-OR merge
    // ---------------------------------------------------------------------

    // At most one way hits, so the OR needs no priority
    always_comb begin
        o_inst = '0;
        for (int w = 0; w < `RV_ICACHE_WAYS; w++)
            o_inst = o_inst | (i_words[w] & {32{i_hits[w]}});
    end

    // Cheaper than a mux tree on the word path, and a
    // miss shows up as a clean zero word

endmodule

// File: src/CacheLookup.sv
// ------------------------------------------------------------------------
// Address split and round-robin replacement for the L1 instruction cache.
// Drives index, tag and offset to every way plus a one-hot victim mask.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module CacheLookup
    import Types::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_rst,       // Sync reset, victims back to way 0
    input  InstAddr    i_addr,      // Core request address
    input  logic       i_lineDone,  // Refill finished, advance victim
    output CacheIndex  o_index,     // Set number
    output CacheTag    o_tag,       // Tag field
    output CacheOffset o_offset,    // Word within line
    output WayMask     o_fillWay);  // One-hot victim of this set

    // Victim counter width, at least one bit
    localparam int WayBits = (`RV_ICACHE_WAYS > 1) ? $clog2(`RV_ICACHE_WAYS) : 1;

    logic [WayBits-1:0] victim [`RV_ICACHE_SETS]; // Next way to replace

    // ---------------------------------------------------------------------
    // Address fields
    // ---------------------------------------------------------------------

    // Bits [1:0] are the byte lane, always word aligned here
    assign o_offset = i_addr[2 +: OffsetBits];
    assign o_index  = i_addr[2 + OffsetBits +: IndexBits];
    assign o_tag    = i_addr[`RV_ADDR_WIDTH-1 -: TagBits];

    // ---------------------------------------------------------------------
    // Round-robin victim per set
    // ---------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int s = 0; s < `RV_ICACHE_SETS; s++)
                victim[s] <= '0;
        end
        else if (i_lineDone) begin
            // Wrap explicitly, count need not fill the counter
            if (victim[o_index] == WayBits'(`RV_ICACHE_WAYS - 1))
                victim[o_index] <= '0;
            else
                victim[o_index] <= victim[o_index] + WayBits'(1);
        end
    end

    // Decode current set's pointer
    assign o_fillWay = WayMask'(1) << victim[o_index];

endmodule

// File: src/CacheWay.sv
// ------------------------------------------------------------------------
// One way of the L1 instruction cache. Holds valid bits, tags and line
// words per set, reports a hit combinationally and takes refill writes.
// ------------------------------------------------------------------------

`timescale 1ns/1ns

`include "Config_macros.svh"

module CacheWay
    import Types::*;
(
    input  logic       i_clock,      // Clock
    input  logic       i_rst,        // Sync reset, clears valid bits
    input  CacheIndex  i_index,      // Set of the request
    input  CacheTag    i_tag,        // Tag of the request
    input  CacheOffset i_offset,     // Word of the request
    input  logic       i_fillEn,     // Write refill word into this way
    input  CacheOffset i_fillOffset, // Word being refilled
    input  Inst        i_fillWord,   // Word from memory
    input  logic       i_lineDone,   // Line complete, this way only
    output logic       o_hit,        // Valid and tag match
    output Inst        o_word);      // Word at i_index/i_offset

    // Storage
    logic [`RV_ICACHE_SETS-1:0] valid;  // One valid bit per set
    CacheTag tags [`RV_ICACHE_SETS];    // Tag per set
    Inst     words [`RV_ICACHE_SETS][`RV_ICACHE_LINE_WORDS];

    // ---------------------------------------------------------------------
    // Valid bits
    // ---------------------------------------------------------------------

    // Cleared as soon as the victim line is overwritten,
    // set again only once the whole line has arrived
    always_ff @(posedge i_clock) begin
        if (i_rst)
            valid <= '0;
        else if (i_lineDone)
            valid[i_index] <= 1'b1;
        else if (i_fillEn)
            valid[i_index] <= 1'b0;   // Line now partly stale
    end

    // ---------------------------------------------------------------------
    // Tag and data arrays
    // ---------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_fillEn)
            words[i_index][i_fillOffset] <= i_fillWord; // One word per take
        if (i_lineDone)
            tags[i_index] <= i_tag;                     // Request still held
    end

    // Read port, fully combinational so a hit costs no wait cycle
    always_comb begin
        o_hit  = valid[i_index] && (tags[i_index] == i_tag);
        o_word = words[i_index][i_offset];
    end

    // Note the word read is meaningless without o_hit,
    // the hit-select stage masks it out

endmodule

// File: src/Types.sv
// ------------------------------------------------------------------------
// Shared types of the instruction memory system. Widths follow the cache
// geometry macros; import with Types::* in the module header.
// ------------------------------------------------------------------------

`include "Config_macros.svh"

package Types;

    // Field widths of a byte address
    localparam int OffsetBits = $clog2(`RV_ICACHE_LINE_WORDS); // Word in line
    localparam int IndexBits  = $clog2(`RV_ICACHE_SETS);       // Set number
    localparam int TagBits    = `RV_ADDR_WIDTH - IndexBits - OffsetBits - 2;

    typedef logic [`RV_ADDR_WIDTH-1:0] InstAddr;   // Byte address
    typedef logic [31:0]               Inst;       // Instruction word

    typedef logic [IndexBits-1:0]      CacheIndex;  // Set select
    typedef logic [OffsetBits-1:0]     CacheOffset; // Word select
    typedef logic [TagBits-1:0]        CacheTag;    // Upper address bits

    typedef logic [`RV_ICACHE_WAYS-1:0] WayMask;   // One bit per way

    // ---------------------------------------------------------------------
    // Refill controller states
    // ---------------------------------------------------------------------
    typedef enum logic [1:0] {
        Idle,    // Waiting for a miss
        Fill,    // Fetching line words from memory
        Finish   // Mark line valid, advance victim
    } RefillState;

endpackage

// File: src/Config_macros.svh
// ------------------------------------------------------------------------
// Build configuration of the instruction memory system. Include it in any
// file that needs the cache switch or the cache geometry.
// ------------------------------------------------------------------------

`ifndef CONFIG_MACROS_SVH
`define CONFIG_MACROS_SVH

// L1 instruction cache on (1) or direct bypass (0)
`define RV_ICACHE_ON 1

// Cache geometry
`define RV_ICACHE_WAYS 2        // Power of two
`define RV_ICACHE_SETS 4        // Sets per way
`define RV_ICACHE_LINE_WORDS 4  // 32-bit words per line

// Byte address width of both buses
`define RV_ADDR_WIDTH 32

// Round-robin replacement needs no extra setting,
// victim pointers live inside the lookup block

`endif
